//--- flist.f
verilog/sq_pkg.sv
verilog/sq_entry_array.sv
verilog/sq_age_mask.sv
verilog/sq_addr_match.sv
verilog/sq_merge_tree.sv
verilog/sq_fwd_select.sv
verilog/store_queue_top.sv
tests/store_queue_asserts.sv
tests/tb_store_queue.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the store queue testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f \
    --top-module tb_store_queue -o tb_store_queue &&
./obj_dir/tb_store_queue | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }

//--- tests/store_queue_cases.txt
// Fields: op_arg_mask_flag_addr_data. Ops: 01 alloc (arg = expected pointer), 02 addr write,
// 03 data write, 04 both, 05 commit x arg, 06 flush, 07 cache credit x arg, 08 load probe
// (arg = load pointer, mask/data/flag = expected mask/data/pending), 09 expect credits = arg.
01_00_0_0_00000000_00000000
01_01_0_0_00000000_00000000
01_02_0_0_00000000_00000000
01_03_0_0_00000000_00000000
04_00_F_0_00000100_11223344
04_01_3_0_00000100_0000BBCC
04_02_F_0_00000200_55555555
04_03_4_0_00000100_00DD0000
08_03_F_0_00000100_1122BBCC
08_04_F_0_00000102_11DDBBCC
08_01_F_0_00000100_11223344
08_03_0_0_00000300_00000000
01_04_0_0_00000000_00000000
02_04_1_0_00000100_00000000
08_05_F_1_00000100_00000000
03_04_0_0_00000000_00000077
08_05_F_0_00000100_11DDBB77
05_03_0_0_00000000_00000000
09_03_0_0_00000000_00000000
07_03_0_0_00000000_00000000
09_06_0_0_00000000_00000000
06_00_0_0_00000000_00000000
08_05_0_0_00000100_00000000
09_08_0_0_00000000_00000000
01_03_0_0_00000000_00000000
04_03_F_0_00000400_01010101
01_04_0_0_00000000_00000000
04_04_F_0_00000500_44444444
01_05_0_0_00000000_00000000
04_05_F_0_00000500_55555555
01_06_0_0_00000000_00000000
04_06_F_0_00000500_66666666
01_07_0_0_00000000_00000000
04_07_1_0_00000400_00000077
01_08_0_0_00000000_00000000
04_00_2_0_00000400_00008800
01_09_0_0_00000000_00000000
04_01_1_0_00000400_00000099
08_09_F_0_00000400_01018877
08_0A_F_0_00000400_01018899
09_01_0_0_00000000_00000000
05_07_0_0_00000000_00000000
07_07_0_0_00000000_00000000
09_08_0_0_00000000_00000000

//--- tests/tb_store_queue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_store_queue import sq_pkg::*; ();
    logic                clk;
    logic                rst;
    logic                alloc_i;
    sq_ptr_u             alloc_ptr_o;
    logic                st_addr_we_i;
    logic [SQ_IDX_W-1:0] st_addr_idx_i;
    logic [ADDR_W-1:0]   st_addr_i;
    logic [BYTES-1:0]    st_mask_i;
    logic                st_data_we_i;
    logic [SQ_IDX_W-1:0] st_data_idx_i;
    logic [DATA_W-1:0]   st_data_i;
    logic                commit_i;
    logic                flush_i;
    logic                cache_credit_i;
    logic                drain_valid_o;
    logic [ADDR_W-1:0]   drain_addr_o;
    logic [BYTES-1:0]    drain_mask_o;
    logic [DATA_W-1:0]   drain_data_o;
    logic                credit_return_o;
    logic                ld_req_i;
    logic [ADDR_W-1:0]   ld_addr_i;
    sq_ptr_u             ld_ptr_i;
    logic                fwd_valid_o;
    logic [BYTES-1:0]    fwd_mask_o;
    logic [DATA_W-1:0]   fwd_data_o;
    logic                fwd_pending_o;

    logic [87:0]         cases [0:127];
    int                  ncases;
    int                  limit;
    int                  cycles;
    int                  credits;   // Dispatcher credits.
    int                  pend_cmt;  // Committed but not yet drained.
    int                  order_q[$]; // Live entries in allocation order.
    logic [ADDR_W-1:0]   m_addr [SQ_SIZE];
    logic [BYTES-1:0]    m_mask [SQ_SIZE];
    logic [DATA_W-1:0]   m_data [SQ_SIZE];

    store_queue_top store_queue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit)
            abort_run("Timeout: the case sequence did not finish in time.");
    end

    // Drains and credit returns are stable between edges.
    always @(negedge clk) begin
        int idx;
        if (!rst && drain_valid_o) begin
            if (pend_cmt == 0 || order_q.size() == 0) begin
                abort_run("A store drained before it was committed.");
            end else begin
                idx = order_q.pop_front();
                pend_cmt--;
                check("drain_addr_o", drain_addr_o, {m_addr[idx][31:2], 2'b00});
                check("drain_mask_o", 32'(drain_mask_o), 32'(m_mask[idx]));
                check("drain_data_o", drain_data_o, m_data[idx]);
            end
        end
        if (!rst && credit_return_o)
            credits++;
    end

    task automatic run_case(input logic [87:0] c);
        logic [7:0]  op;
        logic [7:0]  arg;
        logic [3:0]  mask;
        logic [3:0]  flag;
        logic [31:0] addr;
        logic [31:0] data;
        op = c[87:80];
        arg = c[79:72];
        mask = c[71:68];
        flag = c[67:64];
        addr = c[63:32];
        data = c[31:0];
        case (op)
            8'h01: begin
                check("alloc_ptr_o", 32'(alloc_ptr_o.raw), 32'(arg[3:0]));
                if (credits <= 0)
                    abort_run("Allocation attempted with no dispatcher credit left.");
                credits--;
                order_q.push_back(int'(arg[2:0]));
                alloc_i = 1'b1;
                next_cycle();
                alloc_i = 1'b0;
            end
            8'h02, 8'h03, 8'h04: begin
                if (op != 8'h03) begin
                    m_addr[arg[2:0]] = addr;
                    m_mask[arg[2:0]] = mask;
                    st_addr_we_i = 1'b1;
                    st_addr_idx_i = arg[2:0];
                    st_addr_i = addr;
                    st_mask_i = mask;
                end
                if (op != 8'h02) begin
                    m_data[arg[2:0]] = data;
                    st_data_we_i = 1'b1;
                    st_data_idx_i = arg[2:0];
                    st_data_i = data;
                end
                next_cycle();
                st_addr_we_i = 1'b0;
                st_data_we_i = 1'b0;
            end
            8'h05: begin
                repeat (int'(arg)) begin
                    commit_i = 1'b1;
                    pend_cmt++;
                    next_cycle();
                end
                commit_i = 1'b0;
            end
            8'h06: begin
                // The dispatcher takes back the credits of flushed entries.
                while (order_q.size() > pend_cmt) begin
                    void'(order_q.pop_back());
                    credits++;
                end
                flush_i = 1'b1;
                next_cycle();
                flush_i = 1'b0;
            end
            8'h07: begin
                repeat (int'(arg)) begin
                    cache_credit_i = 1'b1;
                    next_cycle();
                end
                cache_credit_i = 1'b0;
            end
            8'h08: begin
                ld_req_i = 1'b1;
                ld_ptr_i.raw = arg[3:0];
                ld_addr_i = addr;
                next_cycle();
                ld_req_i = 1'b0;
                @(posedge clk);
                @(negedge clk);
                check("fwd_valid_o", 32'(fwd_valid_o), 32'd1);
                check("fwd_mask_o", 32'(fwd_mask_o), 32'(mask));
                check("fwd_pending_o", 32'(fwd_pending_o), 32'(flag[0]));
                if (!flag[0])
                    check("fwd_data_o", fwd_data_o, data);
                next_cycle();
                check("fwd_valid_o", 32'(fwd_valid_o), 32'd0); // One-cycle pulse.
            end
            8'h09: begin
                repeat (2) next_cycle();
                check("dispatcher credits", 32'(credits), 32'(arg));
                check("drain_valid_o", 32'(drain_valid_o), 32'd0);
            end
            default: abort_run("Unknown operation in the case file.");
        endcase
    endtask

    initial begin
        bit failed;
        failed = 1'b0;
        rst = 1'b1;
        alloc_i = 1'b0;
        st_addr_we_i = 1'b0;
        st_addr_idx_i = '0;
        st_addr_i = '0;
        st_mask_i = '0;
        st_data_we_i = 1'b0;
        st_data_idx_i = '0;
        st_data_i = '0;
        commit_i = 1'b0;
        flush_i = 1'b0;
        cache_credit_i = 1'b0;
        ld_req_i = 1'b0;
        ld_addr_i = '0;
        ld_ptr_i = '0;
        cycles = 0;
        limit = 0;
        credits = SQ_SIZE;
        pend_cmt = 0;
        void'($urandom(32'h16e17a19));
        for (int i = 0; i < 128; i++)
            cases[i] = '0;
        $readmemh("tests/store_queue_cases.txt", cases);
        ncases = 0;
        while (ncases < 128 && cases[ncases][87:80] != 8'h00)
            ncases++;
        limit = ncases * 20 + 20;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check("drain_valid_o", 32'(drain_valid_o), 32'd0);
        check("credit_return_o", 32'(credit_return_o), 32'd0);
        check("fwd_valid_o", 32'(fwd_valid_o), 32'd0);
        for (int i = 0; i < ncases; i++) begin
            run_case(cases[i]);
            repeat ($urandom_range(0, 2)) next_cycle(); // Idle gap.
        end
        if (order_q.size() != 0 || credits != SQ_SIZE)
            failed = 1'b1;
        if (!failed) begin
            $display("Simulation PASSED");
        end else begin
            $display("Entries or credits left over at the end of the run.");
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/store_queue_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue_asserts import sq_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_i,
    input  sq_ptr_u            head_q,
    input  sq_ptr_u            cmt_q,
    input  sq_ptr_u            tail_q,
    input  logic [SQ_SIZE-1:0] addr_valid_q,
    input  logic [SQ_SIZE-1:0] data_valid_q,
    input  logic               drain_valid_o,
    input  logic               credit_return_o
);
    logic full;
    logic head_committed;
    logic head_complete;

    assign full = (tail_q.raw ^ head_q.raw) == {1'b1, {SQ_IDX_W{1'b0}}}; // Same index, other lap.

    // Committed entries run from head up to the commit pointer.
    assign head_committed = head_q.raw != cmt_q.raw;
    assign head_complete  = addr_valid_q[head_q.f.idx] & data_valid_q[head_q.f.idx];

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst) alloc_i |-> !full)
        else $error("alloc while the queue is full");
    a_drain_ready: assert property (@(posedge clk) disable iff (rst)
        drain_valid_o |-> head_committed && head_complete)
        else $error("drain of a head entry that is not committed and complete");
    a_credit_after: assert property (@(posedge clk) disable iff (rst)
        drain_valid_o |=> credit_return_o && (head_q.raw == $past(head_q.raw) + 1'b1))
        else $error("no head advance and credit return one cycle after a drain");
    a_credit_cause: assert property (@(posedge clk) disable iff (rst)
        credit_return_o |-> head_q.raw != $past(head_q.raw))
        else $error("credit return without an entry leaving the queue");

endmodule

bind sq_entry_array store_queue_asserts u_asserts (
    .clk             (clk),
    .rst             (rst),
    .alloc_i         (alloc_i),
    .head_q          (head_q),
    .cmt_q           (cmt_q),
    .tail_q          (tail_q),
    .addr_valid_q    (addr_valid_q),
    .data_valid_q    (data_valid_q),
    .drain_valid_o   (drain_valid_o),
    .credit_return_o (credit_return_o)
);

`default_nettype wire

//--- verilog/store_queue_top.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue_top import sq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_i,
    output sq_ptr_u             alloc_ptr_o,
    input  logic                st_addr_we_i,
    input  logic [SQ_IDX_W-1:0] st_addr_idx_i,
    input  logic [ADDR_W-1:0]   st_addr_i,
    input  logic [BYTES-1:0]    st_mask_i,
    input  logic                st_data_we_i,
    input  logic [SQ_IDX_W-1:0] st_data_idx_i,
    input  logic [DATA_W-1:0]   st_data_i,
    input  logic                commit_i,
    input  logic                flush_i,
    input  logic                cache_credit_i,
    output logic                drain_valid_o,
    output logic [ADDR_W-1:0]   drain_addr_o,
    output logic [BYTES-1:0]    drain_mask_o,
    output logic [DATA_W-1:0]   drain_data_o,
    output logic                credit_return_o,
    input  logic                ld_req_i,
    input  logic [ADDR_W-1:0]   ld_addr_i,
    input  sq_ptr_u             ld_ptr_i,
    output logic                fwd_valid_o,
    output logic [BYTES-1:0]    fwd_mask_o,
    output logic [DATA_W-1:0]   fwd_data_o,
    output logic                fwd_pending_o
);
    sq_ptr_u                        head_ptr;
    logic [SQ_SIZE-1:0]             valid;
    logic [SQ_SIZE-1:0]             addr_valid;
    logic [SQ_SIZE-1:0]             data_valid;
    logic [SQ_SIZE-1:0]             dir;
    logic [SQ_SIZE-1:0][ADDR_W-3:0] word_addr;
    logic [SQ_SIZE-1:0][BYTES-1:0]  mask;
    logic [SQ_SIZE-1:0][DATA_W-1:0] data;
    logic [SQ_SIZE-1:0]             older;
    logic [SQ_SIZE-1:0][BYTES-1:0]  match_mask;

    sq_entry_array u_array (
        .clk             (clk),
        .rst             (rst),
        .alloc_i         (alloc_i),
        .st_addr_we_i    (st_addr_we_i),
        .st_addr_idx_i   (st_addr_idx_i),
        .st_addr_i       (st_addr_i),
        .st_mask_i       (st_mask_i),
        .st_data_we_i    (st_data_we_i),
        .st_data_idx_i   (st_data_idx_i),
        .st_data_i       (st_data_i),
        .commit_i        (commit_i),
        .flush_i         (flush_i),
        .cache_credit_i  (cache_credit_i),
        .alloc_ptr_o     (alloc_ptr_o),
        .head_ptr_o      (head_ptr),
        .valid_o         (valid),
        .addr_valid_o    (addr_valid),
        .data_valid_o    (data_valid),
        .dir_o           (dir),
        .word_addr_o     (word_addr),
        .mask_o          (mask),
        .data_o          (data),
        .drain_valid_o   (drain_valid_o),
        .drain_addr_o    (drain_addr_o),
        .drain_mask_o    (drain_mask_o),
        .drain_data_o    (drain_data_o),
        .credit_return_o (credit_return_o)
    );

    sq_age_mask u_age (
        .head_ptr_i (head_ptr),
        .ld_ptr_i   (ld_ptr_i),
        .valid_i    (valid),
        .older_o    (older)
    );

    sq_addr_match u_match (
        .ld_req_i     (ld_req_i),
        .ld_addr_i    (ld_addr_i),
        .word_addr_i  (word_addr),
        .mask_i       (mask),
        .addr_valid_i (addr_valid),
        .match_o      (),
        .match_mask_o (match_mask)
    );

    sq_fwd_select u_fwd (
        .clk           (clk),
        .rst           (rst),
        .ld_req_i      (ld_req_i),
        .ld_ptr_i      (ld_ptr_i),
        .older_i       (older),
        .match_mask_i  (match_mask),
        .dir_i         (dir),
        .data_i        (data),
        .data_valid_i  (data_valid),
        .fwd_valid_o   (fwd_valid_o),
        .fwd_mask_o    (fwd_mask_o),
        .fwd_data_o    (fwd_data_o),
        .fwd_pending_o (fwd_pending_o)
    );

endmodule

`default_nettype wire

//--- verilog/sq_fwd_select.sv
`timescale 1ns/1ns
`default_nettype none

module sq_fwd_select import sq_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ld_req_i,
    input  sq_ptr_u                         ld_ptr_i,
    input  logic [SQ_SIZE-1:0]              older_i,
    input  logic [SQ_SIZE-1:0][BYTES-1:0]   match_mask_i,
    input  logic [SQ_SIZE-1:0]              dir_i,
    input  logic [SQ_SIZE-1:0][DATA_W-1:0]  data_i,
    input  logic [SQ_SIZE-1:0]              data_valid_i,
    output logic                            fwd_valid_o,
    output logic [BYTES-1:0]                fwd_mask_o,
    output logic [DATA_W-1:0]               fwd_data_o,
    output logic                            fwd_pending_o
);
    logic [SQ_SIZE-1:0][BYTES-1:0] cand_mask;
    logic [BYTES-1:0]              sel_mask;
    logic [DATA_W-1:0]             sel_data;
    logic [BYTES-1:0]              sel_dv;
    logic                          s1_valid;
    logic [BYTES-1:0]              s1_mask;
    logic [DATA_W-1:0]             s1_data;
    logic [BYTES-1:0]              s1_dv;

    always_comb begin
        for (int i = 0; i < SQ_SIZE; i++)
            cand_mask[i] = older_i[i] ? match_mask_i[i] : '0; // Older and matching.
    end

    sq_merge_tree u_tree (
        .dir_i        (dir_i),
        .ld_dir_i     (ld_ptr_i.f.dir),
        .mask_i       (cand_mask),
        .data_i       (data_i),
        .data_valid_i (data_valid_i),
        .mask_o       (sel_mask),
        .data_o       (sel_data),
        .data_valid_o (sel_dv),
        .dir_o        (),
        .idx_o        ()
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid      <= 1'b0;
            fwd_valid_o   <= 1'b0;
            fwd_pending_o <= 1'b0;
        end else begin
            s1_valid      <= ld_req_i;
            fwd_valid_o   <= s1_valid;
            fwd_pending_o <= s1_valid & |(s1_mask & ~s1_dv); // A chosen byte lacks data.
        end
    end

    always_ff @(posedge clk) begin
        s1_mask    <= sel_mask;
        s1_data    <= sel_data;
        s1_dv      <= sel_dv;
        fwd_mask_o <= s1_mask;
        fwd_data_o <= s1_data;
    end

endmodule

`default_nettype wire

//--- verilog/sq_merge_tree.sv
`timescale 1ns/1ns
`default_nettype none

module sq_merge_tree import sq_pkg::*; #(
    parameter int N    = SQ_SIZE,
    parameter int BASE = 0
) (
    input  logic [N-1:0]                    dir_i,
    input  logic                            ld_dir_i,
    input  logic [N-1:0][BYTES-1:0]         mask_i,
    input  logic [N-1:0][DATA_W-1:0]        data_i,
    input  logic [N-1:0]                    data_valid_i,
    output logic [BYTES-1:0]                mask_o,
    output logic [DATA_W-1:0]               data_o,
    output logic [BYTES-1:0]                data_valid_o,
    output logic [BYTES-1:0]                dir_o,
    output logic [BYTES-1:0][SQ_IDX_W-1:0]  idx_o
);
    if (N == 1) begin : g_leaf
        // Uncovered bytes read as zero.
        always_comb begin
            for (int b = 0; b < BYTES; b++) begin
                mask_o[b]         = mask_i[0][b];
                data_o[8*b +: 8]  = mask_i[0][b] ? data_i[0][8*b +: 8] : 8'h00;
                data_valid_o[b]   = mask_i[0][b] & data_valid_i[0];
                dir_o[b]          = dir_i[0];
                idx_o[b]          = SQ_IDX_W'(BASE);
            end
        end
    end else begin : g_node
        localparam int NL = N / 2;
        localparam int NH = N - NL;

        logic [BYTES-1:0]               lo_mask;
        logic [BYTES-1:0]               hi_mask;
        logic [DATA_W-1:0]              lo_data;
        logic [DATA_W-1:0]              hi_data;
        logic [BYTES-1:0]               lo_dv;
        logic [BYTES-1:0]               hi_dv;
        logic [BYTES-1:0]               lo_dir;
        logic [BYTES-1:0]               hi_dir;
        logic [BYTES-1:0][SQ_IDX_W-1:0] lo_idx;
        logic [BYTES-1:0][SQ_IDX_W-1:0] hi_idx;

        sq_merge_tree #(.N(NL), .BASE(BASE)) u_lo (
            .dir_i        (dir_i[NL-1:0]),
            .ld_dir_i     (ld_dir_i),
            .mask_i       (mask_i[NL-1:0]),
            .data_i       (data_i[NL-1:0]),
            .data_valid_i (data_valid_i[NL-1:0]),
            .mask_o       (lo_mask),
            .data_o       (lo_data),
            .data_valid_o (lo_dv),
            .dir_o        (lo_dir),
            .idx_o        (lo_idx)
        );

        sq_merge_tree #(.N(NH), .BASE(BASE + NL)) u_hi (
            .dir_i        (dir_i[N-1:NL]),
            .ld_dir_i     (ld_dir_i),
            .mask_i       (mask_i[N-1:NL]),
            .data_i       (data_i[N-1:NL]),
            .data_valid_i (data_valid_i[N-1:NL]),
            .mask_o       (hi_mask),
            .data_o       (hi_data),
            .data_valid_o (hi_dv),
            .dir_o        (hi_dir),
            .idx_o        (hi_idx)
        );

        always_comb begin
            logic [SQ_IDX_W:0] lo_key;
            logic [SQ_IDX_W:0] hi_key;
            logic              pick_hi;
            for (int b = 0; b < BYTES; b++) begin
                // Same lap as the load means younger, then higher index.
                lo_key  = {lo_dir[b] == ld_dir_i, lo_idx[b]};
                hi_key  = {hi_dir[b] == ld_dir_i, hi_idx[b]};
                pick_hi = hi_mask[b] & (~lo_mask[b] | (hi_key > lo_key));
                mask_o[b]        = lo_mask[b] | hi_mask[b];
                data_o[8*b +: 8] = pick_hi ? hi_data[8*b +: 8] : lo_data[8*b +: 8];
                data_valid_o[b]  = pick_hi ? hi_dv[b] : lo_dv[b];
                dir_o[b]         = pick_hi ? hi_dir[b] : lo_dir[b];
                idx_o[b]         = pick_hi ? hi_idx[b] : lo_idx[b];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_addr_match.sv
`timescale 1ns/1ns
`default_nettype none

module sq_addr_match import sq_pkg::*; (
    input  logic                            ld_req_i,
    input  logic [ADDR_W-1:0]               ld_addr_i,
    input  logic [SQ_SIZE-1:0][ADDR_W-3:0]  word_addr_i,
    input  logic [SQ_SIZE-1:0][BYTES-1:0]   mask_i,
    input  logic [SQ_SIZE-1:0]              addr_valid_i,
    output logic [SQ_SIZE-1:0]              match_o,
    output logic [SQ_SIZE-1:0][BYTES-1:0]   match_mask_o
);
    logic [ADDR_W-3:0] ld_word;

    assign ld_word = ld_addr_i[ADDR_W-1:2]; // Word granularity.

    always_comb begin
        for (int i = 0; i < SQ_SIZE; i++) begin
            match_o[i] = ld_req_i & addr_valid_i[i] & (word_addr_i[i] == ld_word);
            match_mask_o[i] = match_o[i] ? mask_i[i] : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_age_mask.sv
`timescale 1ns/1ns
`default_nettype none

module sq_age_mask import sq_pkg::*; (
    input  sq_ptr_u            head_ptr_i,
    input  sq_ptr_u            ld_ptr_i,
    input  logic [SQ_SIZE-1:0] valid_i,
    output logic [SQ_SIZE-1:0] older_o
);
    logic [SQ_SIZE-1:0] head_below;
    logic [SQ_SIZE-1:0] ld_below;
    logic [SQ_SIZE-1:0] span;
    logic               wrap;

    // Thermometer masks of entries below each pointer.
    always_comb begin
        for (int i = 0; i < SQ_SIZE; i++) begin
            head_below[i] = SQ_IDX_W'(i) < head_ptr_i.f.idx;
            ld_below[i]   = SQ_IDX_W'(i) < ld_ptr_i.f.idx;
        end
    end

    assign wrap = head_ptr_i.f.dir ^ ld_ptr_i.f.dir;

    // Span from head up to the load pointer, inverted when it wraps.
    assign span = wrap ? ~(head_below ^ ld_below) : (head_below ^ ld_below);

    assign older_o = span & valid_i;

endmodule

`default_nettype wire

//--- verilog/sq_entry_array.sv
`timescale 1ns/1ns
`default_nettype none

module sq_entry_array import sq_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alloc_i,
    input  logic                            st_addr_we_i,
    input  logic [SQ_IDX_W-1:0]             st_addr_idx_i,
    input  logic [ADDR_W-1:0]               st_addr_i,
    input  logic [BYTES-1:0]                st_mask_i,
    input  logic                            st_data_we_i,
    input  logic [SQ_IDX_W-1:0]             st_data_idx_i,
    input  logic [DATA_W-1:0]               st_data_i,
    input  logic                            commit_i,
    input  logic                            flush_i,
    input  logic                            cache_credit_i,
    output sq_ptr_u                         alloc_ptr_o,
    output sq_ptr_u                         head_ptr_o,
    output logic [SQ_SIZE-1:0]              valid_o,
    output logic [SQ_SIZE-1:0]              addr_valid_o,
    output logic [SQ_SIZE-1:0]              data_valid_o,
    output logic [SQ_SIZE-1:0]              dir_o,
    output logic [SQ_SIZE-1:0][ADDR_W-3:0]  word_addr_o,
    output logic [SQ_SIZE-1:0][BYTES-1:0]   mask_o,
    output logic [SQ_SIZE-1:0][DATA_W-1:0]  data_o,
    output logic                            drain_valid_o,
    output logic [ADDR_W-1:0]               drain_addr_o,
    output logic [BYTES-1:0]                drain_mask_o,
    output logic [DATA_W-1:0]               drain_data_o,
    output logic                            credit_return_o
);
    sq_ptr_u                        head_q;
    sq_ptr_u                        cmt_q;
    sq_ptr_u                        tail_q;
    sq_ptr_u                        cmt_n;
    logic [SQ_SIZE-1:0]             valid_q;
    logic [SQ_SIZE-1:0]             addr_valid_q;
    logic [SQ_SIZE-1:0]             data_valid_q;
    logic [SQ_SIZE-1:0]             committed_q;
    logic [SQ_SIZE-1:0]             dir_q;
    logic [SQ_SIZE-1:0][ADDR_W-3:0] waddr_q;
    logic [SQ_SIZE-1:0][BYTES-1:0]  mask_q;
    logic [SQ_SIZE-1:0][DATA_W-1:0] data_q;
    logic [SQ_IDX_W:0]              cache_cnt_q; // Drain credits from the cache.
    logic [SQ_IDX_W-1:0]            hidx;

    assign hidx = head_q.f.idx;
    assign cmt_n.raw = cmt_q.raw + {{SQ_IDX_W{1'b0}}, commit_i};

    // A credit arriving this cycle may be spent at once.
    assign drain_valid_o = valid_q[hidx] & addr_valid_q[hidx] & data_valid_q[hidx]
                         & committed_q[hidx] & ((cache_cnt_q != '0) | cache_credit_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q          <= '0;
            cmt_q           <= '0;
            tail_q          <= '0;
            valid_q         <= '0;
            addr_valid_q    <= '0;
            data_valid_q    <= '0;
            committed_q     <= '0;
            cache_cnt_q     <= '0;
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= drain_valid_o; // Dispatcher credit back.
            cmt_q <= cmt_n;
            case ({cache_credit_i, drain_valid_o})
                2'b10:   cache_cnt_q <= cache_cnt_q + 1'b1;
                2'b01:   cache_cnt_q <= cache_cnt_q - 1'b1;
                default: cache_cnt_q <= cache_cnt_q;
            endcase
            if (drain_valid_o) begin
                head_q.raw    <= head_q.raw + 1'b1;
                valid_q[hidx] <= 1'b0;
            end
            if (commit_i)
                committed_q[cmt_q.f.idx] <= 1'b1;
            if (alloc_i && !flush_i) begin
                valid_q[tail_q.f.idx]      <= 1'b1;
                addr_valid_q[tail_q.f.idx] <= 1'b0;
                data_valid_q[tail_q.f.idx] <= 1'b0;
                committed_q[tail_q.f.idx]  <= 1'b0;
                tail_q.raw <= tail_q.raw + 1'b1;
            end
            if (st_addr_we_i)
                addr_valid_q[st_addr_idx_i] <= 1'b1;
            if (st_data_we_i)
                data_valid_q[st_data_idx_i] <= 1'b1;
            if (flush_i) begin
                tail_q <= cmt_n;
                for (int i = 0; i < SQ_SIZE; i++) begin
                    // Keep what is committed, including a commit in this cycle.
                    if (!committed_q[i] && !(commit_i && cmt_q.f.idx == SQ_IDX_W'(i)))
                        valid_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i && !flush_i)
            dir_q[tail_q.f.idx] <= tail_q.f.dir;
        if (st_addr_we_i) begin
            waddr_q[st_addr_idx_i] <= st_addr_i[ADDR_W-1:2];
            mask_q[st_addr_idx_i]  <= st_mask_i;
        end
        if (st_data_we_i)
            data_q[st_data_idx_i] <= st_data_i;
    end

    assign alloc_ptr_o  = tail_q;
    assign head_ptr_o   = head_q;
    assign valid_o      = valid_q;
    assign addr_valid_o = addr_valid_q;
    assign data_valid_o = data_valid_q;
    assign dir_o        = dir_q;
    assign word_addr_o  = waddr_q;
    assign mask_o       = mask_q;
    assign data_o       = data_q;

    assign drain_addr_o = {waddr_q[hidx], 2'b00};
    assign drain_mask_o = mask_q[hidx];
    assign drain_data_o = data_q[hidx];

endmodule

`default_nettype wire

//--- verilog/sq_pkg.sv
`default_nettype none

package sq_pkg;

    localparam int SQ_SIZE  = 8;
    localparam int SQ_IDX_W = 3;
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTES    = 4;

    // Index plus a lap bit that flips each time the pointer wraps.
    typedef struct packed {
        logic                dir;
        logic [SQ_IDX_W-1:0] idx;
    } sq_ptr_s;

    // Raw view for increment, field view everywhere else.
    typedef union packed {
        logic [SQ_IDX_W:0] raw;
        sq_ptr_s           f;
    } sq_ptr_u;

endpackage

`default_nettype wire
